// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // datapath sizes
    localparam int DATA_W   = 8;
    localparam int NUM_REGS = 4;
    localparam int ADDR_W   = 11;   // 3 bits from byte one, 8 from byte two

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [1:0]        reg_idx_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // base operation, inst[7:5]
    localparam logic [2:0] BASE_CTRL = 3'd0;
    localparam logic [2:0] BASE_ADD  = 3'd1;
    localparam logic [2:0] BASE_SUB  = 3'd2;
    localparam logic [2:0] BASE_AND  = 3'd3;
    localparam logic [2:0] BASE_OR   = 3'd4;
    localparam logic [2:0] BASE_XOR  = 3'd5;

    // alu byte: immediate follows when set
    localparam int IMM_BIT = 4;

    // control group, inst[4:3]
    localparam logic [1:0] CTRL_MISC = 2'd0;
    localparam logic [1:0] CTRL_JMP  = 2'd1;

    // misc group, inst[2:0]
    localparam logic [2:0] MISC_NOP      = 3'd0;
    localparam logic [2:0] MISC_HALT     = 3'd2;
    localparam logic [2:0] MISC_SET_BCZ  = 3'd3;
    localparam logic [2:0] MISC_SET_BCNZ = 3'd4;
    localparam logic [2:0] MISC_CLR_BC   = 3'd5;

    typedef enum logic [2:0] {
        EX_NOP,
        EX_ADD,
        EX_SUB,
        EX_AND,
        EX_OR,
        EX_XOR,
        EX_JMP
    } exec_op_e;

    // branch control bits of the control register
    typedef struct packed {
        logic bcz;
        logic bcnz;
    } bc_t;

    typedef struct packed {
        logic z;
        logic nz;
        logic ovf;   // carry on add, borrow on sub
    } flags_t;

    // one decoded operation, decode to execute
    typedef struct packed {
        logic     valid;
        exec_op_e op;
        reg_idx_t src0;
        reg_idx_t src1;
        reg_idx_t dst;
        logic     use_imm;
        data_t    imm;
        addr_t    target;
        bc_t      bc;      // control bits as seen by this jmp
    } dec_op_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dst;
        data_t    data;
        flags_t   flags;
    } wb_t;

    typedef struct packed {
        logic  valid;
        logic  taken;
        addr_t target;
    } branch_t;

endpackage

`default_nettype wire

// ==== inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  logic             clk,
    input  logic             reset_,
    input  logic             inst_valid,
    input  cpu_pkg::data_t   inst,
    output cpu_pkg::dec_op_t dec_op,
    output logic             halted
);
    import cpu_pkg::*;

    logic    accept;
    logic    pending;      // waiting for second byte
    logic    pend_nxt;
    data_t   first_q;      // first byte of a two-byte inst
    data_t   first_nxt;
    bc_t     bc_q;
    bc_t     bc_nxt;
    logic    halt_set;
    logic    bad_op;
    dec_op_t dec_nxt;

    // base field to alu operation, EX_NOP when not an alu base
    function automatic exec_op_e alu_op(input logic [2:0] base);
        case (base)
            BASE_ADD: return EX_ADD;
            BASE_SUB: return EX_SUB;
            BASE_AND: return EX_AND;
            BASE_OR:  return EX_OR;
            BASE_XOR: return EX_XOR;
            default:  return EX_NOP;
        endcase
    endfunction

    assign accept = inst_valid & ~halted;

    always_comb begin
        dec_nxt   = '0;
        pend_nxt  = pending;
        first_nxt = first_q;
        bc_nxt    = bc_q;
        halt_set  = 1'b0;
        bad_op    = 1'b0;

        if (accept) begin
            if (pending) begin
                // second byte completes jmp or alu immediate
                pend_nxt      = 1'b0;
                dec_nxt.valid = 1'b1;
                if (first_q[7:5] == BASE_CTRL) begin
                    dec_nxt.op     = EX_JMP;
                    dec_nxt.target = {first_q[2:0], inst};
                    dec_nxt.bc     = bc_q;   // program order snapshot
                end else begin
                    dec_nxt.op      = alu_op(first_q[7:5]);
                    dec_nxt.src0    = first_q[3:2];
                    dec_nxt.src1    = first_q[1:0];
                    dec_nxt.dst     = first_q[1:0];
                    dec_nxt.use_imm = 1'b1;
                    dec_nxt.imm     = inst;
                end
            end else if (inst[7:5] == BASE_CTRL) begin
                case (inst[4:3])
                    CTRL_MISC: begin
                        case (inst[2:0])
                            MISC_HALT:     halt_set    = 1'b1;
                            MISC_SET_BCZ:  bc_nxt.bcz  = 1'b1;
                            MISC_SET_BCNZ: bc_nxt.bcnz = 1'b1;
                            MISC_CLR_BC:   bc_nxt      = '0;
                            default:       bad_op      = (inst[2:0] != MISC_NOP);
                        endcase
                    end
                    CTRL_JMP: begin
                        pend_nxt  = 1'b1;
                        first_nxt = inst;
                    end
                    default: bad_op = 1'b1;
                endcase
            end else if (alu_op(inst[7:5]) != EX_NOP) begin
                if (inst[IMM_BIT]) begin
                    pend_nxt  = 1'b1;
                    first_nxt = inst;
                end else begin
                    dec_nxt.valid = 1'b1;
                    dec_nxt.op    = alu_op(inst[7:5]);
                    dec_nxt.src0  = inst[3:2];
                    dec_nxt.src1  = inst[1:0];
                    dec_nxt.dst   = inst[1:0];
                end
            end else begin
                bad_op = 1'b1;   // bases 6 and 7, run as nop
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            pending <= 1'b0;
            bc_q    <= '0;
            halted  <= 1'b0;
            dec_op  <= '0;
        end else begin
            pending <= pend_nxt;
            bc_q    <= bc_nxt;
            halted  <= halted | halt_set;   // sticky
            dec_op  <= dec_nxt;
        end
    end

    // byte store, only meaningful while pending
    always_ff @(posedge clk) begin
        first_q <= first_nxt;
    end

    // unknown codes reach here only from a broken program
    a_no_bad_op: assert property (@(posedge clk) disable iff (!reset_)
        !bad_op)
        else $error("illegal instruction byte %02x accepted", inst);

endmodule

`default_nettype wire

// ==== alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  logic              clk,
    input  logic              reset_,
    input  cpu_pkg::dec_op_t  dec_op,
    output cpu_pkg::reg_idx_t rd_idx0,
    output cpu_pkg::reg_idx_t rd_idx1,
    input  cpu_pkg::data_t    rd_data0,
    input  cpu_pkg::data_t    rd_data1,
    input  cpu_pkg::flags_t   flags,
    output cpu_pkg::wb_t      exec_wb,
    output cpu_pkg::branch_t  exec_br
);
    import cpu_pkg::*;

    data_t           opnd_b;
    logic [DATA_W:0] full;   // extra bit holds carry or borrow
    data_t           res;
    logic            taken;

    assign rd_idx0 = dec_op.src0;
    assign rd_idx1 = dec_op.src1;

    assign opnd_b = dec_op.use_imm ? dec_op.imm : rd_data1;

    always_comb begin
        case (dec_op.op)
            EX_ADD:  full = {1'b0, rd_data0} + {1'b0, opnd_b};
            EX_SUB:  full = {1'b0, rd_data0} - {1'b0, opnd_b};
            EX_AND:  full = {1'b0, rd_data0 & opnd_b};
            EX_OR:   full = {1'b0, rd_data0 | opnd_b};
            EX_XOR:  full = {1'b0, rd_data0 ^ opnd_b};
            default: full = '0;
        endcase
    end

    assign res = full[DATA_W-1:0];

    // branch rule from control bits and current flags
    always_comb begin
        case ({dec_op.bc.bcz, dec_op.bc.bcnz})
            2'b11:   taken = flags.ovf;
            2'b10:   taken = flags.z;
            2'b01:   taken = flags.nz;
            default: taken = 1'b1;   // unconditional
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            exec_wb <= '0;
            exec_br <= '0;
        end else begin
            exec_wb.valid     <= dec_op.valid && (dec_op.op != EX_JMP);
            exec_wb.dst       <= dec_op.dst;
            exec_wb.data      <= res;
            exec_wb.flags.z   <= (res == '0);
            exec_wb.flags.nz  <= (res != '0);
            exec_wb.flags.ovf <= full[DATA_W];   // zero for logic ops
            exec_br.valid     <= dec_op.valid && (dec_op.op == EX_JMP);
            exec_br.taken     <= taken;
            exec_br.target    <= dec_op.target;
        end
    end

    a_one_result: assert property (@(posedge clk) disable iff (!reset_)
        !(exec_wb.valid && exec_br.valid))
        else $error("write-back and branch issued together");

    // decode must drop nop instead of issuing it
    a_no_nop_issue: assert property (@(posedge clk) disable iff (!reset_)
        dec_op.valid |-> dec_op.op != EX_NOP)
        else $error("nop issued to execute");

endmodule

`default_nettype wire

// ==== reg_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_result (
    input  logic              clk,
    input  logic              reset_,
    input  cpu_pkg::wb_t      exec_wb,
    input  cpu_pkg::branch_t  exec_br,
    input  cpu_pkg::reg_idx_t rd_idx0,
    input  cpu_pkg::reg_idx_t rd_idx1,
    output cpu_pkg::data_t    rd_data0,
    output cpu_pkg::data_t    rd_data1,
    output cpu_pkg::flags_t   flags,
    output cpu_pkg::wb_t      wb,
    output cpu_pkg::branch_t  branch
);
    import cpu_pkg::*;

    data_t  regs [NUM_REGS];
    flags_t sr_q;            // status register

    // pending write-back wins over stored state
    assign rd_data0 = (exec_wb.valid && exec_wb.dst == rd_idx0) ? exec_wb.data
                                                                 : regs[rd_idx0];
    assign rd_data1 = (exec_wb.valid && exec_wb.dst == rd_idx1) ? exec_wb.data
                                                                 : regs[rd_idx1];
    assign flags    = exec_wb.valid ? exec_wb.flags : sr_q;

    always_ff @(posedge clk) begin
        if (!reset_) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            sr_q <= '0;
        end else if (exec_wb.valid) begin
            regs[exec_wb.dst] <= exec_wb.data;
            sr_q              <= exec_wb.flags;
        end
    end

    // committed results out, same edge as the commit
    always_ff @(posedge clk) begin
        if (!reset_) begin
            wb     <= '0;
            branch <= '0;
        end else begin
            wb     <= exec_wb;
            branch <= exec_br;
        end
    end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic             clk,
    input  logic             reset_,
    input  logic             inst_valid,
    input  cpu_pkg::data_t   inst,
    output cpu_pkg::wb_t     wb,
    output cpu_pkg::branch_t branch,
    output logic             halted
);
    import cpu_pkg::*;

    dec_op_t  dec_op;
    wb_t      exec_wb;
    branch_t  exec_br;
    reg_idx_t rd_idx0;
    reg_idx_t rd_idx1;
    data_t    rd_data0;
    data_t    rd_data1;
    flags_t   flags;

    inst_decode inst_decode_inst (
        .clk        (clk),
        .reset_     (reset_),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_op     (dec_op),
        .halted     (halted)
    );

    alu_execute alu_execute_inst (
        .clk      (clk),
        .reset_   (reset_),
        .dec_op   (dec_op),
        .rd_idx0  (rd_idx0),
        .rd_idx1  (rd_idx1),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .flags    (flags),      // forwarded status
        .exec_wb  (exec_wb),
        .exec_br  (exec_br)
    );

    reg_result reg_result_inst (
        .clk      (clk),
        .reset_   (reset_),
        .exec_wb  (exec_wb),
        .exec_br  (exec_br),
        .rd_idx0  (rd_idx0),
        .rd_idx1  (rd_idx1),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .flags    (flags),
        .wb       (wb),
        .branch   (branch)
    );

endmodule

`default_nettype wire

// ==== tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    // rough cost of each test in cycles
    localparam int IMM_CYCLES    = 4 * 6;
    localparam int REG_CYCLES    = 10 * 6;
    localparam int B2B_CYCLES    = 8 + 5;
    localparam int BRANCH_CYCLES = 12 * 11;
    localparam int HALT_CYCLES   = 20;
    localparam int MARGIN_CYCLES = 100;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IMM_CYCLES + REG_CYCLES + B2B_CYCLES
                                   + BRANCH_CYCLES + HALT_CYCLES + MARGIN_CYCLES;

    logic        clk;
    logic        reset_;
    logic        inst_valid;
    data_t       inst;
    wb_t         wb;
    branch_t     branch;
    logic        halted;

    data_t       model_regs [NUM_REGS];   // reference register file
    flags_t      model_flags;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int unsigned seed;

    cpu_core cpu_core_inst (
        .clk        (clk),
        .reset_     (reset_),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb         (wb),
        .branch     (branch),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic data_t alu_byte(input logic [2:0] base, input logic imm,
                                       input reg_idx_t s0, input reg_idx_t d);
        return {base, imm, s0, d};
    endfunction

    function automatic data_t misc_byte(input logic [2:0] code);
        return {BASE_CTRL, CTRL_MISC, code};
    endfunction

    // reference alu updates the model like a committed write-back
    function automatic wb_t model_alu(input logic [2:0] base, input reg_idx_t s0,
                                      input data_t b, input reg_idx_t d);
        data_t a;
        data_t r;
        logic  ovf;
        wb_t   exp;
        a   = model_regs[s0];
        ovf = 1'b0;
        case (base)
            BASE_ADD: begin
                r   = a + b;
                ovf = (int'(a) + int'(b)) > 255;   // carry out
            end
            BASE_SUB: begin
                r   = a - b;
                ovf = int'(b) > int'(a);           // borrow
            end
            BASE_AND: r = a & b;
            BASE_OR:  r = a | b;
            default:  r = a ^ b;
        endcase
        exp.valid     = 1'b1;
        exp.dst       = d;
        exp.data      = r;
        exp.flags.z   = (r == '0);
        exp.flags.nz  = (r != '0);
        exp.flags.ovf = ovf;
        model_regs[d] = r;
        model_flags   = exp.flags;
        return exp;
    endfunction

    function automatic logic branch_taken(input bc_t bc, input flags_t f);
        if (bc.bcz && bc.bcnz) return f.ovf;
        if (bc.bcz) return f.z;
        if (bc.bcnz) return f.nz;
        return 1'b1;   // no condition bits means always jump
    endfunction

    function automatic string wb_text(input wb_t w);
        return $sformatf("dst=%0d data=%02h flags=%03b", w.dst, w.data, w.flags);
    endfunction

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act.valid !== 1'b1) begin
            $display("%s: the write-back strobe did not arrive when expected", name);
            errors++;
        end else if (act !== exp) begin
            $display("[ERROR] %s expected %s actual %s", name, wb_text(exp), wb_text(act));
            errors++;
        end
    endtask

    task automatic check_branch(input string name, input branch_t exp, input branch_t act);
        if (act.valid !== 1'b1) begin
            $display("%s: the branch strobe did not arrive when expected", name);
            errors++;
        end else if (act !== exp) begin
            $display("[ERROR] %s expected taken=%0b target=%03h actual taken=%0b target=%03h",
                     name, exp.taken, exp.target, act.taken, act.target);
            errors++;
        end
    endtask

    task automatic send_byte(input data_t b);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= b;
    endtask

    // result due on the third edge and not before
    task automatic settle_and_check(input string name, input logic want_br,
                                    input wb_t exp_wb, input branch_t exp_br);
        @(posedge clk);
        inst_valid <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            if ((want_br ? branch.valid : wb.valid) === 1'b1) begin
                $display("%s: a result strobe arrived before the third cycle", name);
                errors++;
            end
            @(posedge clk);
        end
        @(negedge clk);
        if (want_br) check_branch(name, exp_br, branch);
        else check_wb(name, exp_wb, wb);
    endtask

    task automatic reg_op(input string name, input logic [2:0] base,
                          input reg_idx_t s0, input reg_idx_t d);
        wb_t exp;
        send_byte(alu_byte(base, 1'b0, s0, d));
        exp = model_alu(base, s0, model_regs[d], d);
        settle_and_check(name, 1'b0, exp, '0);
    endtask

    task automatic imm_op(input string name, input logic [2:0] base,
                          input reg_idx_t s0, input reg_idx_t d, input data_t v);
        wb_t exp;
        send_byte(alu_byte(base, 1'b1, s0, d));
        send_byte(v);
        exp = model_alu(base, s0, v, d);
        settle_and_check(name, 1'b0, exp, '0);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic load_all_regs();
        int errs;
        errs = errors;
        for (int r = 0; r < NUM_REGS; r++) begin
            imm_op($sformatf("imm_load r%0d", r), BASE_ADD, reg_idx_t'(r), reg_idx_t'(r),
                   data_t'($urandom));
        end
        end_test("imm_load", errs);
    endtask

    task automatic run_reg_forms();
        int errs;
        errs = errors;
        reg_op("clear r0", BASE_XOR, 2'd0, 2'd0);
        imm_op("load r0", BASE_ADD, 2'd0, 2'd0, 8'hC8);
        reg_op("clear r1", BASE_XOR, 2'd1, 2'd1);
        imm_op("load r1", BASE_ADD, 2'd1, 2'd1, 8'h5A);
        reg_op("add carry", BASE_ADD, 2'd0, 2'd1);     // c8 + 5a wraps
        reg_op("sub borrow", BASE_SUB, 2'd1, 2'd0);    // 22 - c8
        reg_op("and", BASE_AND, 2'd0, 2'd2);
        reg_op("or", BASE_OR, 2'd1, 2'd3);
        reg_op("xor zero", BASE_XOR, 2'd2, 2'd2);
        reg_op("sub zero", BASE_SUB, 2'd3, 2'd3);
        end_test("reg_forms", errs);
    endtask

    task automatic chain_back_to_back();
        data_t      bytes [$];
        wb_t        exp_q [$];
        reg_idx_t   d;
        reg_idx_t   s0;
        logic [2:0] base;
        int         errs;
        errs = errors;
        d    = 2'd0;
        for (int i = 0; i < 8; i++) begin
            s0   = d;   // reads the previous result
            // steps 2 and 5 keep dst so src1 is forwarded as well
            if (i != 2 && i != 5) begin
                d = reg_idx_t'(i + 1);
            end
            base = 3'(1 + i % 5);
            bytes.push_back(alu_byte(base, 1'b0, s0, d));
            exp_q.push_back(model_alu(base, s0, model_regs[d], d));
        end
        fork
            begin
                foreach (bytes[i]) send_byte(bytes[i]);
                @(posedge clk);
                inst_valid <= 1'b0;
            end
            begin
                repeat (4) @(posedge clk);
                foreach (exp_q[i]) begin
                    @(negedge clk);
                    check_wb($sformatf("back_to_back op %0d", i), exp_q[i], wb);
                    if (i < exp_q.size() - 1) @(posedge clk);
                end
            end
        join
        end_test("back_to_back", errs);
    endtask

    task automatic resolve_branches();
        bc_t     bc;
        addr_t   tgt;
        branch_t exp;
        data_t   v;
        int      errs;
        errs = errors;
        for (int s = 0; s < 4; s++) begin
            bc.bcz  = (s == 0 || s == 2);
            bc.bcnz = (s == 1 || s == 2);
            for (int c = 0; c < 3; c++) begin
                send_byte(misc_byte(MISC_CLR_BC));
                if (bc.bcz) send_byte(misc_byte(MISC_SET_BCZ));
                if (bc.bcnz) send_byte(misc_byte(MISC_SET_BCNZ));
                v = (c == 1) ? 8'hFF : data_t'($urandom);
                if (c == 0) begin
                    send_byte(alu_byte(BASE_XOR, 1'b0, 2'd0, 2'd0));   // zero result
                    void'(model_alu(BASE_XOR, 2'd0, model_regs[0], 2'd0));
                end else begin
                    send_byte(alu_byte(BASE_ADD, 1'b1, reg_idx_t'(c), reg_idx_t'(c)));
                    send_byte(v);
                    void'(model_alu(BASE_ADD, reg_idx_t'(c), v, reg_idx_t'(c)));
                end
                tgt = addr_t'($urandom);
                send_byte({BASE_CTRL, CTRL_JMP, tgt[10:8]});
                send_byte(tgt[7:0]);
                exp.valid  = 1'b1;
                exp.taken  = branch_taken(bc, model_flags);
                exp.target = tgt;
                settle_and_check($sformatf("branch bc=%0b%0b case %0d", bc.bcz, bc.bcnz, c),
                                 1'b1, '0, exp);
            end
        end
        end_test("branch_cond", errs);
    endtask

    task automatic stop_on_halt();
        wb_t   exp;
        data_t v;
        int    errs;
        errs = errors;
        v    = data_t'($urandom);
        exp  = model_alu(BASE_ADD, 2'd3, v, 2'd3);
        send_byte(alu_byte(BASE_ADD, 1'b1, 2'd3, 2'd3));
        send_byte(v);
        send_byte(misc_byte(MISC_HALT));
        send_byte(alu_byte(BASE_XOR, 1'b0, 2'd0, 2'd0));   // dropped by halt
        send_byte(alu_byte(BASE_SUB, 1'b0, 2'd1, 2'd1));
        @(negedge clk);
        check_wb("halt in flight", exp, wb);
        if (halted !== 1'b1) begin
            $display("halt: halted did not rise after the HALT byte");
            errors++;
        end
        // watch covers the slots of every byte sent after the halt
        fork
            begin
                send_byte(alu_byte(BASE_OR, 1'b1, 2'd2, 2'd2));
                send_byte(8'h5A);
                @(posedge clk);
                inst_valid <= 1'b0;
            end
            repeat (8) begin
                @(negedge clk);
                if (wb.valid === 1'b1) begin
                    $display("halt: a write-back strobe arrived after the core halted");
                    errors++;
                end
            end
        join
        end_test("halt", errs);
    endtask

    initial begin
        seed = 69;
        void'($urandom(seed));
        reset_       = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_flags  = '0;
        for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_ <= 1'b1;

        load_all_regs();
        run_reg_forms();
        chain_back_to_back();
        resolve_branches();
        stop_on_halt();   // halt is sticky so it runs last

        repeat (2) @(posedge clk);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
cpu_pkg.sv
inst_decode.sv
alu_execute.sv
reg_result.sv
cpu_core.sv
tb_cpu_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_cpu_core

out=$(./obj_dir/Vtb_cpu_core)
printf '%s\n' "$out"

# exit status follows the search
printf '%s\n' "$out" | grep -qx 'RESULT: PASS'
